//--- run_sim.sh
#!/usr/bin/env bash
# build and run the Sv32 MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module mmu_tb -o mmu_tb_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mmu_tb_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb.f
verilog/mmu_pkg.sv
verilog/sv32_tlb.sv
verilog/pte_check.sv
verilog/page_walker.sv
verilog/mem_port_mux.sv
verilog/sv32_mmu.sv
tests/mmu_assertions.sv
tests/mmu_tb.sv

//--- tests/mmu_assertions.sv
/*
 * MMU memory port assertions
 * one strobe at a time, stable requests under back-pressure, quiet in IDLE
 */
`timescale 1ns/1ps

module mmu_assertions (
    input logic                     CLK,
    input logic                     arst_n,
    input mmu_pkg::walk_state_t     state,
    input logic [mmu_pkg::XLEN-1:0] mem_addr,
    input logic                     mem_le,
    input logic                     mem_we,
    input logic                     mem_busy
);
    import mmu_pkg::*;

    int fail_count = 0;

    a_one_strobe: assert property (@(posedge CLK) disable iff (!arst_n)
        !(mem_le && mem_we))
        else begin
            fail_count++;
            $error("load and write strobes are high together");
        end

    // a request not yet accepted keeps its address and strobe
    a_hold_request: assert property (@(posedge CLK) disable iff (!arst_n)
        (mem_le || mem_we) && mem_busy |=> $stable(mem_addr) && $stable(mem_le) &&
        $stable(mem_we))
        else begin
            fail_count++;
            $error("memory request changed while waiting on busy");
        end

    a_idle_quiet: assert property (@(posedge CLK) disable iff (!arst_n)
        state == IDLE |-> !mem_le && !mem_we)
        else begin
            fail_count++;
            $error("memory strobe raised while the walker is idle");
        end

endmodule

bind sv32_mmu mmu_assertions assert_i (
    .CLK(CLK), .arst_n(arst_n), .state(state), .mem_addr(mem_addr),
    .mem_le(mem_le), .mem_we(mem_we), .mem_busy(mem_busy)
);

//--- tests/mmu_input.txt
# M addr word | T access priv satp_mode satp_ppn mxr sum vaddr wdata fault cause_or_rdata
# F flushes the TLBs | C addr word; access 1 code 2 read 3 write, priv 0 U 1 S 3 M
M 00001004 00000801
M 00001008 000000CF
M 00002000 00000C4B
M 00002004 00000C07
M 0000200C 00000C05
M 00002010 00000CD7
M 00002014 00000C49
M 00002018 00000C01
M 0000201C 00000C43
T 2 3 1 1 0 0 00000100 00000000 0 01000100
T 3 1 0 1 0 0 00000200 CAFE0200 0 00000000
C 00000200 CAFE0200
T 1 1 1 1 0 0 00400000 00000000 0 30003000
T 2 1 1 1 0 0 00800100 00000000 0 01000100
T 3 1 1 1 0 0 00800040 00C0FFEE 0 00000000
C 00000040 00C0FFEE
T 2 1 1 1 0 0 00401010 00000000 0 30103010
C 00002004 00000C47
T 3 1 1 1 0 0 00401020 12345678 0 00000000
C 00002004 00000CC7
C 00003020 12345678
T 3 1 1 1 0 0 00402000 DEAD0000 1 0000000F
T 3 1 1 1 0 0 00403000 DEAD0001 1 0000000F
C 00003000 30003000
T 2 1 1 1 0 0 00404000 00000000 1 0000000D
T 2 1 1 1 0 1 00404010 00000000 0 30103010
F
T 2 0 1 1 0 0 00401010 00000000 1 0000000D
T 2 0 1 1 0 0 00404010 00000000 0 30103010
T 2 1 1 1 0 0 00405000 00000000 1 0000000D
T 2 1 1 1 1 0 00405000 00000000 0 30003000
T 1 1 1 1 0 0 00401000 00000000 1 0000000C
T 2 1 1 1 0 0 00406000 00000000 1 0000000D
T 2 1 1 1 0 0 00407010 00000000 0 30103010
T 3 3 1 1 0 0 0000201C 00000043 0 00000000
T 2 1 1 1 0 0 00407010 00000000 0 30103010
F
T 2 1 1 1 0 0 00407010 00000000 0 00100010

//--- tests/mmu_tb.sv
/*
 * Sv32 MMU testbench
 * file-driven transactions against a word memory with random busy lengths
 */
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int MEM_WORDS = 4096;

    typedef logic [9:0][31:0] fields_t;

    logic             CLK;
    logic             arst_n;
    access_t          access;
    priv_t            priv;
    logic [XLEN-1:0]  vaddr;
    logic [XLEN-1:0]  wdata;
    logic             satp_mode;
    logic [PPN_W-1:0] satp_ppn;
    logic             mxr;
    logic             sum;
    logic             tlb_flush;
    logic             busy;
    logic [XLEN-1:0]  rdata;
    logic             fault;
    cause_t           fault_cause;
    logic [XLEN-1:0]  mem_addr;
    logic [XLEN-1:0]  mem_wdata;
    logic             mem_le;
    logic             mem_we;
    logic [XLEN-1:0]  mem_rdata = '0;
    logic             mem_busy = 1'b0;

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [31:0]      rng = 32'd85645;
    int               busy_left = 0;
    int               n_txn = 0;
    byte              kinds[$];
    fields_t          recs[$];

    sv32_mmu dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // memory model, one request at a time, busy for 1 to 3 cycles after acceptance
    always @(negedge CLK) begin
        if (busy_left != 0) begin
            mem_busy <= 1'b1;
            busy_left = busy_left - 1;
        end else begin
            mem_busy <= 1'b0;
            if (mem_le || mem_we) begin
                if (mem_we) begin
                    mem[mem_addr[13:2]] = mem_wdata;
                end
                mem_rdata <= mem[mem_addr[13:2]];
                rng = xorshift(rng);
                busy_left = 1 + int'(rng % 3);
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic load_stimulus();
        int      fd;
        string   line;
        byte     kind;
        fields_t f;
        fd = $fopen("tests/mmu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/mmu_input.txt");
            $display("Some tests failed");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            f = '0;
            kind = 8'h00;
            void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1],
                          f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
            if (kind == "M") begin
                mem[f[0][13:2]] = f[1];
            end else if (kind == "T" || kind == "F" || kind == "C") begin
                kinds.push_back(kind);
                recs.push_back(f);
                if (kind == "T") begin
                    n_txn++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one request, held until busy drops
    task automatic run_txn(input int idx, input fields_t f);
        string name;
        name = $sformatf("record %0d", idx);
        access = access_t'(f[0][1:0]);
        priv = priv_t'(f[1][1:0]);
        satp_mode = f[2][0];
        satp_ppn = f[3][PPN_W-1:0];
        mxr = f[4][0];
        sum = f[5][0];
        vaddr = f[6];
        wdata = f[7];
        @(negedge CLK);
        while (busy) @(negedge CLK);
        check_value({name, " fault"}, f[8], 32'(fault));
        if (f[8][0]) begin
            check_value({name, " cause"}, 32'(cause_t'(f[9][3:0])), 32'(fault_cause));
        end else if (access != ACC_WRITE) begin
            check_value({name, " rdata"}, f[9], rdata);
        end
        access = ACC_NONE;
    endtask

    initial begin
        arst_n = 1'b0;
        access = ACC_NONE;
        priv = PRIV_M;
        vaddr = '0;
        wdata = '0;
        satp_mode = 1'b0;
        satp_ppn = '0;
        mxr = 1'b0;
        sum = 1'b0;
        tlb_flush = 1'b0;
        // background word is the byte address in both halves, V bit clear
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {2{16'(i * 4)}};
        end
        load_stimulus();
        repeat (8) @(negedge CLK);
        arst_n = 1'b1;
        foreach (kinds[i]) begin
            @(negedge CLK);
            if (kinds[i] == "T") begin
                run_txn(i, recs[i]);
            end else if (kinds[i] == "F") begin
                tlb_flush = 1'b1;
                @(negedge CLK);
                tlb_flush = 1'b0;
            end else begin
                check_value($sformatf("record %0d memory", i), recs[i][1],
                            mem[recs[i][0][13:2]]);
            end
        end
        @(negedge CLK);
        if (n_txn == 0 || dut_i.assert_i.fail_count != 0) begin
            $display("no transactions were run or a memory port assertion failed");
            $display("Some tests failed");
            $fatal(1);
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    // watchdog sized from the transaction count
    initial begin
        @(posedge arst_n);
        repeat (n_txn * 60) @(posedge CLK);
        $display("timeout: the MMU did not finish the transactions in time");
        $display("Some tests failed");
        $fatal(1);
    end

endmodule

//--- verilog/mem_port_mux.sv
/*
 * Memory port mux
 * address, write data and strobes toward memory for each walker state
 */
`timescale 1ns/1ps

module mem_port_mux (
    input  mmu_pkg::walk_state_t      state,
    input  mmu_pkg::access_t          access,
    input  logic [mmu_pkg::XLEN-1:0]  vaddr,
    input  logic [mmu_pkg::XLEN-1:0]  wdata,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    input  logic [mmu_pkg::XLEN-1:0]  cur_pte,
    input  logic [mmu_pkg::XLEN-1:0]  pte_new,
    input  logic [mmu_pkg::XLEN-1:0]  paddr,
    output logic [mmu_pkg::XLEN-1:0]  mem_addr,
    output logic [mmu_pkg::XLEN-1:0]  mem_wdata,
    output logic                      mem_le,
    output logic                      mem_we
);
    import mmu_pkg::*;

    always_comb begin
        mem_addr  = paddr;
        mem_wdata = wdata;
        mem_le    = 1'b0;
        mem_we    = 1'b0;
        case (state)
            L1_READ: begin
                mem_addr = pte_addr(satp_ppn, vaddr[31:22]);
                mem_le   = 1'b1;
            end
            L0_READ: begin
                // next table comes from the level 1 pointer
                mem_addr = pte_addr(cur_pte[PTE_PPN_LSB +: PPN_W], vaddr[21:12]);
                mem_le   = 1'b1;
            end
            PTE_WRITE: begin
                // paddr still holds the entry address here
                mem_wdata = pte_new;
                mem_we    = 1'b1;
            end
            ACCESS: begin
                mem_le = (access == ACC_CODE) || (access == ACC_READ);
                mem_we = (access == ACC_WRITE);
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/mmu_pkg.sv
/*
 * Sv32 MMU shared definitions
 * widths, TLB geometry, PTE bit positions, enums and PTE address helpers
 */
package mmu_pkg;

    localparam int XLEN        = 32;
    localparam int PPN_W       = 20;
    localparam int VPN_W       = 20;
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    localparam int TLB_TAG_W   = VPN_W - TLB_IDX_W;

    // page table entry flag positions
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;
    // ppn field starts here, 20 bits wide
    localparam int PTE_PPN_LSB = 10;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_CODE,
        ACC_READ,
        ACC_WRITE
    } access_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [3:0] {
        CAUSE_FETCH_PF = 4'd12,
        CAUSE_LOAD_PF  = 4'd13,
        CAUSE_STORE_PF = 4'd15
    } cause_t;

    typedef enum logic [3:0] {
        IDLE,
        L1_READ,
        L1_WAIT,
        L0_READ,
        L0_WAIT,
        CHECK,
        PTE_WRITE,
        ACCESS,
        ACCESS_WAIT,
        DONE
    } walk_state_t;

    // entry address: table base page plus 4 * index
    function automatic logic [XLEN-1:0] pte_addr(input logic [PPN_W-1:0] base,
                                                 input logic [9:0] idx);
        return {base, idx, 2'b00};
    endfunction

    // physical page of a leaf, superpage keeps vpn0 from the virtual address
    function automatic logic [PPN_W-1:0] leaf_ppn(input logic [XLEN-1:0] pte,
                                                  input logic level,
                                                  input logic [XLEN-1:0] vaddr);
        return level ? {pte[PTE_PPN_LSB+10 +: 10], vaddr[21:12]} : pte[PTE_PPN_LSB +: PPN_W];
    endfunction

endpackage

//--- verilog/page_walker.sv
/*
 * Sv32 page walker
 * TLB lookup, two-level walk, A/D write-back and the final memory access
 */
`timescale 1ns/1ps

module page_walker (
    input  logic                      CLK,
    input  logic                      arst_n,
    input  mmu_pkg::access_t          access,
    input  logic [mmu_pkg::XLEN-1:0]  vaddr,
    input  mmu_pkg::priv_t            priv,
    input  logic                      satp_mode,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    input  logic [mmu_pkg::XLEN-1:0]  mem_rdata,
    input  logic                      mem_busy,
    input  logic                      hit,
    input  logic [mmu_pkg::PPN_W-1:0] hit_ppn,
    input  logic                      pte_leaf,
    input  logic                      pte_fault,
    input  logic                      pte_update,
    output mmu_pkg::walk_state_t      state,
    output logic [mmu_pkg::XLEN-1:0]  cur_pte,
    output logic                      level,
    output logic [mmu_pkg::XLEN-1:0]  paddr,
    output logic                      fill_code,
    output logic                      fill_dread,
    output logic                      fill_dwrite,
    output logic                      busy,
    output logic [mmu_pkg::XLEN-1:0]  rdata,
    output logic                      fault,
    output mmu_pkg::cause_t           fault_cause
);
    import mmu_pkg::*;

    logic             bypass;
    logic             fill;
    logic [PPN_W-1:0] phys_ppn;

    // machine mode or bare satp skip translation
    assign bypass   = (priv == PRIV_M) || !satp_mode;
    assign phys_ppn = leaf_ppn(cur_pte, level, vaddr);

    // fill after a clean leaf, or once the A/D write is accepted
    assign fill = (state == CHECK && pte_leaf && !pte_fault && !pte_update) ||
                  (state == PTE_WRITE && !mem_busy);

    assign fill_code   = fill && (access == ACC_CODE);
    assign fill_dread  = fill && (access == ACC_READ);
    assign fill_dwrite = fill && (access == ACC_WRITE);

    assign busy = (access != ACC_NONE) && (state != DONE);

    always_comb begin
        case (access)
            ACC_CODE:  fault_cause = CAUSE_FETCH_PF;
            ACC_WRITE: fault_cause = CAUSE_STORE_PF;
            default:   fault_cause = CAUSE_LOAD_PF;
        endcase
    end

    // walk control
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            level <= 1'b1;
            fault <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (access != ACC_NONE) begin
                        if (bypass || hit) begin
                            state <= ACCESS;
                        end else begin
                            state <= L1_READ;
                            level <= 1'b1;
                        end
                    end
                end
                L1_READ: if (!mem_busy) state <= L1_WAIT;
                L1_WAIT: if (!mem_busy) state <= CHECK;
                L0_READ: if (!mem_busy) state <= L0_WAIT;
                L0_WAIT: if (!mem_busy) state <= CHECK;
                CHECK: begin
                    if (pte_fault) begin
                        fault <= 1'b1;
                        state <= DONE;
                    end else if (!pte_leaf) begin
                        // pointer at level 1, descend
                        level <= 1'b0;
                        state <= L0_READ;
                    end else if (pte_update) begin
                        state <= PTE_WRITE;
                    end else begin
                        state <= ACCESS;
                    end
                end
                PTE_WRITE:   if (!mem_busy) state <= ACCESS;
                ACCESS:      if (!mem_busy) state <= ACCESS_WAIT;
                ACCESS_WAIT: if (!mem_busy) state <= DONE;
                DONE: begin
                    state <= IDLE;
                    fault <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latched entry, address and load data
    always_ff @(posedge CLK) begin
        case (state)
            IDLE: begin
                if (bypass) begin
                    paddr <= vaddr;
                end else if (hit) begin
                    paddr <= {hit_ppn, vaddr[11:0]};
                end else begin
                    paddr <= pte_addr(satp_ppn, vaddr[31:22]);
                end
            end
            L1_WAIT, L0_WAIT: begin
                if (!mem_busy) begin
                    cur_pte <= mem_rdata;
                end
            end
            CHECK: begin
                // keep the entry address while a write-back is pending
                if (!pte_leaf) begin
                    paddr <= pte_addr(cur_pte[PTE_PPN_LSB +: PPN_W], vaddr[21:12]);
                end else if (!pte_update) begin
                    paddr <= {phys_ppn, vaddr[11:0]};
                end
            end
            PTE_WRITE: begin
                if (!mem_busy) begin
                    paddr <= {phys_ppn, vaddr[11:0]};
                end
            end
            ACCESS_WAIT: begin
                if (!mem_busy) begin
                    rdata <= mem_rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/pte_check.sv
/*
 * PTE checker
 * leaf, fault and accessed/dirty update verdict for one page table entry
 */
`timescale 1ns/1ps

module pte_check (
    input  logic [mmu_pkg::XLEN-1:0] pte,
    input  logic                     level,
    input  mmu_pkg::access_t         access,
    input  mmu_pkg::priv_t           priv,
    input  logic                     mxr,
    input  logic                     sum,
    output logic                     pte_leaf,
    output logic                     pte_fault,
    output logic                     pte_update,
    output logic [mmu_pkg::XLEN-1:0] pte_new
);
    import mmu_pkg::*;

    logic is_write;
    logic malformed;
    logic perm_ok;
    logic priv_ok;

    assign is_write = (access == ACC_WRITE);

    // invalid entry or the reserved W-without-R encoding
    assign malformed = !pte[PTE_V] || (pte[PTE_W] && !pte[PTE_R]);
    assign pte_leaf  = pte[PTE_V] && (pte[PTE_R] || pte[PTE_X]);

    // required permission bit, mxr lets X stand in for R
    always_comb begin
        case (access)
            ACC_CODE:  perm_ok = pte[PTE_X];
            ACC_READ:  perm_ok = pte[PTE_R] || (mxr && pte[PTE_X]);
            ACC_WRITE: perm_ok = pte[PTE_W];
            default:   perm_ok = 1'b0;
        endcase
    end

    assign priv_ok = !((priv == PRIV_S && pte[PTE_U] && !sum) ||
                       (priv == PRIV_U && !pte[PTE_U]));

    always_comb begin
        if (malformed) begin
            pte_fault = 1'b1;
        end else if (pte_leaf) begin
            pte_fault = !(perm_ok && priv_ok);
        end else begin
            // pointer entry is only legal at level 1
            pte_fault = !level;
        end
    end

    assign pte_update = pte_leaf && !pte_fault && (!pte[PTE_A] || (is_write && !pte[PTE_D]));

    // write-back value with A set, D too for a store
    always_comb begin
        pte_new        = pte;
        pte_new[PTE_A] = 1'b1;
        if (is_write) begin
            pte_new[PTE_D] = 1'b1;
        end
    end

endmodule

//--- verilog/sv32_mmu.sv
/*
 * Sv32 MMU top
 * walker, PTE checker, code/read/write TLBs and the memory port
 */
`timescale 1ns/1ps

module sv32_mmu (
    input  logic                      CLK,
    input  logic                      arst_n,
    input  mmu_pkg::access_t          access,
    input  logic [mmu_pkg::XLEN-1:0]  vaddr,
    input  logic [mmu_pkg::XLEN-1:0]  wdata,
    input  mmu_pkg::priv_t            priv,
    input  logic                      satp_mode,
    input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
    input  logic                      mxr,
    input  logic                      sum,
    input  logic                      tlb_flush,
    input  logic [mmu_pkg::XLEN-1:0]  mem_rdata,
    input  logic                      mem_busy,
    output logic                      busy,
    output logic [mmu_pkg::XLEN-1:0]  rdata,
    output logic                      fault,
    output mmu_pkg::cause_t           fault_cause,
    output logic [mmu_pkg::XLEN-1:0]  mem_addr,
    output logic [mmu_pkg::XLEN-1:0]  mem_wdata,
    output logic                      mem_le,
    output logic                      mem_we
);
    import mmu_pkg::*;

    walk_state_t      state;
    logic [XLEN-1:0]  cur_pte;
    logic [XLEN-1:0]  pte_new;
    logic [XLEN-1:0]  paddr;
    logic             level;
    logic             pte_leaf;
    logic             pte_fault;
    logic             pte_update;
    logic             fill_code;
    logic             fill_dread;
    logic             fill_dwrite;
    logic [PPN_W-1:0] fill_ppn;
    logic             hit;
    logic [PPN_W-1:0] hit_ppn;
    logic             code_hit;
    logic             dread_hit;
    logic             dwrite_hit;
    logic [PPN_W-1:0] code_ppn;
    logic [PPN_W-1:0] dread_ppn;
    logic [PPN_W-1:0] dwrite_ppn;

    assign fill_ppn = leaf_ppn(cur_pte, level, vaddr);

    // TLB of the requested kind
    always_comb begin
        case (access)
            ACC_CODE:  {hit, hit_ppn} = {code_hit, code_ppn};
            ACC_READ:  {hit, hit_ppn} = {dread_hit, dread_ppn};
            ACC_WRITE: {hit, hit_ppn} = {dwrite_hit, dwrite_ppn};
            default:   {hit, hit_ppn} = '0;
        endcase
    end

    page_walker walker_i (
        .CLK(CLK), .arst_n(arst_n), .access(access), .vaddr(vaddr), .priv(priv),
        .satp_mode(satp_mode), .satp_ppn(satp_ppn), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy), .hit(hit), .hit_ppn(hit_ppn), .pte_leaf(pte_leaf),
        .pte_fault(pte_fault), .pte_update(pte_update), .state(state), .cur_pte(cur_pte),
        .level(level), .paddr(paddr), .fill_code(fill_code), .fill_dread(fill_dread),
        .fill_dwrite(fill_dwrite), .busy(busy), .rdata(rdata), .fault(fault),
        .fault_cause(fault_cause)
    );

    pte_check check_i (
        .pte(cur_pte), .level(level), .access(access), .priv(priv), .mxr(mxr), .sum(sum),
        .pte_leaf(pte_leaf), .pte_fault(pte_fault), .pte_update(pte_update),
        .pte_new(pte_new)
    );

    sv32_tlb tlb_code (
        .CLK(CLK), .arst_n(arst_n), .flush(tlb_flush), .fill(fill_code),
        .lookup_vpn(vaddr[31:12]), .fill_ppn(fill_ppn), .hit(code_hit), .hit_ppn(code_ppn)
    );

    sv32_tlb tlb_dread (
        .CLK(CLK), .arst_n(arst_n), .flush(tlb_flush), .fill(fill_dread),
        .lookup_vpn(vaddr[31:12]), .fill_ppn(fill_ppn), .hit(dread_hit),
        .hit_ppn(dread_ppn)
    );

    sv32_tlb tlb_dwrite (
        .CLK(CLK), .arst_n(arst_n), .flush(tlb_flush), .fill(fill_dwrite),
        .lookup_vpn(vaddr[31:12]), .fill_ppn(fill_ppn), .hit(dwrite_hit),
        .hit_ppn(dwrite_ppn)
    );

    mem_port_mux mux_i (
        .state(state), .access(access), .vaddr(vaddr), .wdata(wdata), .satp_ppn(satp_ppn),
        .cur_pte(cur_pte), .pte_new(pte_new), .paddr(paddr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_le(mem_le), .mem_we(mem_we)
    );

endmodule

//--- verilog/sv32_tlb.sv
/*
 * Sv32 TLB
 * direct-mapped translation cache, vpn low bits index, rest is the tag
 */
`timescale 1ns/1ps

module sv32_tlb (
    input  logic                       CLK,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       fill,
    input  logic [mmu_pkg::VPN_W-1:0]  lookup_vpn,
    input  logic [mmu_pkg::PPN_W-1:0]  fill_ppn,
    output logic                       hit,
    output logic [mmu_pkg::PPN_W-1:0]  hit_ppn
);
    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0] valid;
    logic [TLB_TAG_W-1:0]   tag_mem [TLB_ENTRIES];
    logic [PPN_W-1:0]       ppn_mem [TLB_ENTRIES];

    logic [TLB_IDX_W-1:0]   idx;
    logic [TLB_TAG_W-1:0]   tag;

    assign {tag, idx} = lookup_vpn;

    // combinational lookup
    assign hit     = valid[idx] && (tag_mem[idx] == tag);
    assign hit_ppn = ppn_mem[idx];

    // valid bits, flush wins over a fill in the same cycle
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[idx] <= 1'b1;
        end
    end

    // tag and ppn storage
    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[idx] <= tag;
            ppn_mem[idx] <= fill_ppn;
        end
    end

endmodule
